// File: collect_pkg.sv
// collection path shared definitions
// sample type, source and sender state encodings, default sizes
`default_nettype none

package collect_pkg;

  // one collected byte, same width for every source
  typedef logic [7:0] sample_t;

  // active byte source after priority encoding
  typedef enum logic [1:0] {
    SRC_NONE = 2'd0,  // no mode toggle set
    SRC_ADC  = 2'd1,
    SRC_UDP  = 2'd2,
    SRC_LINK = 2'd3
  } src_sel_e;

  // packet sender states
  typedef enum logic {
    PKT_IDLE = 1'b0,  // waiting for a full packet in the fifo
    PKT_SEND = 1'b1   // draining one packet, credit permitting
  } pkt_state_e;

  // key 0 is transmit enable, keys 1..3 pick adc, udp, link
  localparam int NUM_KEYS = 4;

  // debounce length in sys_clk cycles, fits in 20 bits
  localparam int DEF_CNT_MAX = 999_999;

  // fifo depth in bytes, power of two and a multiple of the packet length
  localparam int DEF_FIFO_DEPTH = 64;

  // bytes per packet
  localparam int DEF_PKT_LEN = 16;

  // credits the udp transmitter grants after reset
  localparam int DEF_CREDITS = 8;

endpackage

`default_nettype wire

// File: collect_top.f
collect_pkg.sv
key_filter.sv
source_select.sv
sample_fifo.sv
pkt_sender.sv
collect_top.sv
tb_collect_top.sv

// File: collect_top.sv
// multi-source collection top
// key debounce and source selection, sample fifo, packet sender to udp tx
`default_nettype none
`timescale 1ns/100ps

module collect_top #(
  parameter int CNT_MAX    = collect_pkg::DEF_CNT_MAX,
  parameter int FIFO_DEPTH = collect_pkg::DEF_FIFO_DEPTH,
  parameter int PKT_LEN    = collect_pkg::DEF_PKT_LEN,
  parameter int CREDITS    = collect_pkg::DEF_CREDITS
) (
  input  logic                             sys_clk,
  input  logic                             sys_rst_n,
  input  logic [collect_pkg::NUM_KEYS-1:0] keys,         // active low
  input  collect_pkg::sample_t             adc_data,
  input  logic                             adc_valid,
  input  collect_pkg::sample_t             udp_rx_data,
  input  logic                             udp_rx_valid,
  input  collect_pkg::sample_t             link_data,
  input  logic                             link_valid,
  input  logic                             tx_credit,
  output collect_pkg::sample_t             tx_data,
  output logic                             tx_valid,
  output logic                             tx_sop,
  output logic                             tx_eop,
  output logic                             overflow
);

  import collect_pkg::*;

  localparam int LW = $clog2(FIFO_DEPTH) + 1;

  logic [NUM_KEYS-1:0] key_flag;
  sample_t             sel_data;
  logic                sel_valid;
  logic                tx_en;
  sample_t             rd_data;
  logic [LW-1:0]       level;
  logic                rd_en;

  // one debouncer per key
  for (genvar i = 0; i < NUM_KEYS; i++) begin : g_key
    key_filter #(.CNT_MAX(CNT_MAX)) key_filter_inst (
      .sys_clk  (sys_clk),
      .sys_rst_n(sys_rst_n),
      .key_in   (keys[i]),
      .key_flag (key_flag[i])
    );
  end

  source_select source_select_inst (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .key_flag    (key_flag),
    .adc_data    (adc_data),
    .adc_valid   (adc_valid),
    .udp_rx_data (udp_rx_data),
    .udp_rx_valid(udp_rx_valid),
    .link_data   (link_data),
    .link_valid  (link_valid),
    .sel_data    (sel_data),
    .sel_valid   (sel_valid),
    .tx_en       (tx_en)
  );

  sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) sample_fifo_inst (
    .sys_clk  (sys_clk),
    .sys_rst_n(sys_rst_n),
    .wr_data  (sel_data),
    .wr_en    (sel_valid),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .level    (level),
    .overflow (overflow)
  );

  pkt_sender #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .PKT_LEN   (PKT_LEN),
    .CREDITS   (CREDITS)
  ) pkt_sender_inst (
    .sys_clk  (sys_clk),
    .sys_rst_n(sys_rst_n),
    .tx_en    (tx_en),
    .level    (level),
    .rd_data  (rd_data),
    .rd_en    (rd_en),
    .tx_credit(tx_credit),
    .tx_data  (tx_data),
    .tx_valid (tx_valid),
    .tx_sop   (tx_sop),
    .tx_eop   (tx_eop)
  );

endmodule

`default_nettype wire

// File: key_filter.sv
// push key debounce
// one active-low key in, a single-cycle flag per press out
`default_nettype none
`timescale 1ns/100ps

module key_filter #(
  parameter int CNT_MAX = collect_pkg::DEF_CNT_MAX
) (
  input  logic sys_clk,
  input  logic sys_rst_n,
  input  logic key_in,    // active low
  output logic key_flag
);

  localparam int CW = $clog2(CNT_MAX + 1);
  localparam logic [CW-1:0] CNT_END = CW'(CNT_MAX);

  logic [CW-1:0] cnt;  // consecutive low samples

  // count while pressed, saturate at the end so a long press flags once
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      cnt <= '0;
    end else if (key_in) begin
      cnt <= '0;  // released or bouncing high
    end else if (cnt != CNT_END) begin
      cnt <= cnt + 1'b1;
    end
  end

  // fires on the sample that makes CNT_MAX lows in a row
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      key_flag <= 1'b0;
    end else begin
      key_flag <= !key_in && (cnt == CNT_END - 1'b1);
    end
  end

endmodule

`default_nettype wire

// File: pkt_sender.sv
// packet sender
// cuts the fifo stream into PKT_LEN byte packets for the udp transmitter
// and paces the bytes with a credit counter
`default_nettype none
`timescale 1ns/100ps

module pkt_sender #(
  parameter int FIFO_DEPTH = collect_pkg::DEF_FIFO_DEPTH,
  parameter int PKT_LEN    = collect_pkg::DEF_PKT_LEN,
  parameter int CREDITS    = collect_pkg::DEF_CREDITS
) (
  input  logic                          sys_clk,
  input  logic                          sys_rst_n,
  input  logic                          tx_en,
  input  logic [$clog2(FIFO_DEPTH):0]   level,
  input  collect_pkg::sample_t          rd_data,
  output logic                          rd_en,
  input  logic                          tx_credit,  // one credit back per pulse
  output collect_pkg::sample_t          tx_data,
  output logic                          tx_valid,
  output logic                          tx_sop,
  output logic                          tx_eop
);

  import collect_pkg::*;

  localparam int LW = $clog2(FIFO_DEPTH) + 1;
  localparam int BW = (PKT_LEN > 1) ? $clog2(PKT_LEN) : 1;
  localparam int CW = $clog2(CREDITS + 1);
  localparam logic [LW-1:0] PKT_LVL  = LW'(PKT_LEN);
  localparam logic [BW-1:0] LAST_POS = BW'(PKT_LEN - 1);
  localparam logic [CW-1:0] CRED_MAX = CW'(CREDITS);

  pkt_state_e    state;
  logic [BW-1:0] byte_cnt;  // position inside the packet
  logic [CW-1:0] credit;
  logic          send;
  logic          last;

  // credit is judged before this cycle's return is added
  assign send  = (state == PKT_SEND) && (credit != '0);
  assign last  = (byte_cnt == LAST_POS);
  assign rd_en = send;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state    <= PKT_IDLE;
      byte_cnt <= '0;
    end else begin
      case (state)
        PKT_IDLE: begin
          // a whole packet must be buffered before the first byte goes
          if (tx_en && level >= PKT_LVL) state <= PKT_SEND;
        end
        PKT_SEND: begin
          if (send) begin
            byte_cnt <= last ? '0 : byte_cnt + 1'b1;
            if (last) state <= PKT_IDLE;  // tx_en drop only acts here
          end
        end
        default: state <= PKT_IDLE;
      endcase
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      credit <= CRED_MAX;
    end else begin
      credit <= credit + CW'(tx_credit) - CW'(send);
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      tx_valid <= 1'b0;
      tx_sop   <= 1'b0;
      tx_eop   <= 1'b0;
    end else begin
      tx_valid <= send;
      tx_sop   <= send && (byte_cnt == '0);
      tx_eop   <= send && last;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (send) tx_data <= rd_data;
  end

  // the transmitter never hands back more than it was given
  a_credit_bound: assert property (
    @(posedge sys_clk) disable iff (!sys_rst_n)
    credit <= CRED_MAX
  );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build the collection testbench with Verilator, run it, judge by the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_collect_top -f collect_top.f
./obj_dir/Vtb_collect_top > sim.log 2>&1 || true
cat sim.log
if grep -q "^Everything OK$" sim.log; then
  exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

// File: sample_fifo.sv
// sample fifo
// circular byte buffer between source select and the packet sender,
// zero-latency head, fill level, drops writes when full
`default_nettype none
`timescale 1ns/100ps

module sample_fifo #(
  parameter int FIFO_DEPTH = collect_pkg::DEF_FIFO_DEPTH
) (
  input  logic                          sys_clk,
  input  logic                          sys_rst_n,
  input  collect_pkg::sample_t          wr_data,
  input  logic                          wr_en,
  input  logic                          rd_en,
  output collect_pkg::sample_t          rd_data,
  output logic [$clog2(FIFO_DEPTH):0]   level,
  output logic                          overflow
);

  import collect_pkg::*;

  localparam int AW = $clog2(FIFO_DEPTH);
  localparam int LW = AW + 1;
  localparam logic [LW-1:0] FULL_LVL = LW'(FIFO_DEPTH);

  sample_t       mem [FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic          full;
  logic          empty;
  logic          wr_do;
  logic          rd_do;

  assign full  = (level == FULL_LVL);
  assign empty = (level == '0);
  assign wr_do = wr_en && !full;   // byte lost when full
  assign rd_do = rd_en && !empty;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      level    <= '0;
      overflow <= 1'b0;
    end else begin
      if (wr_do) wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
      if (rd_do) rd_ptr <= rd_ptr + 1'b1;
      level <= level + LW'(wr_do) - LW'(rd_do);
      if (wr_en && full) begin
        overflow <= 1'b1;  // sticky until reset
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (wr_do) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  assign rd_data = mem[rd_ptr];  // head byte, no read latency

  // the sender only pops bytes it has seen counted
  a_no_read_when_empty: assert property (
    @(posedge sys_clk) disable iff (!sys_rst_n)
    rd_en |-> !empty
  );

endmodule

`default_nettype wire

// File: source_select.sv
// source selection
// key flags toggle the mode bits, the first set mode among adc, udp and
// link wins, and the chosen byte with its strobe is registered once
`default_nettype none
`timescale 1ns/100ps

module source_select (
  input  logic                          sys_clk,
  input  logic                          sys_rst_n,
  input  logic [collect_pkg::NUM_KEYS-1:0] key_flag,
  input  collect_pkg::sample_t          adc_data,
  input  logic                          adc_valid,
  input  collect_pkg::sample_t          udp_rx_data,
  input  logic                          udp_rx_valid,
  input  collect_pkg::sample_t          link_data,
  input  logic                          link_valid,
  output collect_pkg::sample_t          sel_data,
  output logic                          sel_valid,
  output logic                          tx_en
);

  import collect_pkg::*;

  // mode bit positions
  localparam int KEY_TX   = 0;
  localparam int KEY_ADC  = 1;
  localparam int KEY_UDP  = 2;
  localparam int KEY_LINK = 3;

  logic [NUM_KEYS-1:0] mode;        // one toggle per key
  src_sel_e            src_sel;
  sample_t             pick_data;
  logic                pick_valid;

  // each flag flips its own toggle
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      mode <= '0;
    end else begin
      mode <= mode ^ key_flag;
    end
  end

  assign tx_en = mode[KEY_TX];

  // adc over udp over link
  always_comb begin
    if (mode[KEY_ADC])       src_sel = SRC_ADC;
    else if (mode[KEY_UDP])  src_sel = SRC_UDP;
    else if (mode[KEY_LINK]) src_sel = SRC_LINK;
    else                     src_sel = SRC_NONE;
  end

  always_comb begin
    pick_data  = adc_data;
    pick_valid = 1'b0;  // SRC_NONE accepts nothing
    case (src_sel)
      SRC_ADC: begin
        pick_data  = adc_data;
        pick_valid = adc_valid;
      end
      SRC_UDP: begin
        pick_data  = udp_rx_data;
        pick_valid = udp_rx_valid;
      end
      SRC_LINK: begin
        pick_data  = link_data;
        pick_valid = link_valid;
      end
      default: ;
    endcase
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      sel_valid <= 1'b0;
    end else begin
      sel_valid <= pick_valid;
    end
  end

  always_ff @(posedge sys_clk) begin
    sel_data <= pick_data;  // qualified by sel_valid
  end

endmodule

`default_nettype wire

// File: tb_collect_top.sv
// testbench for the collection top
// drives keys and the three byte sources, models the selection and
// checks packet bytes and framing against credit-paced output
`default_nettype none
`timescale 1ns/100ps

module tb_collect_top;

  import collect_pkg::*;

  localparam int CNT_MAX    = 4;
  localparam int FIFO_DEPTH = DEF_FIFO_DEPTH;
  localparam int PKT_LEN    = DEF_PKT_LEN;
  localparam int CREDITS    = DEF_CREDITS;
  localparam int SEED       = 32'ha14e2d65;
  // about 8 key presses of 17 cycles plus roughly 360 bytes, padded well
  localparam int MAX_CYCLES = 4000;

  logic                sys_clk = 1'b0;
  logic                sys_rst_n;
  logic [NUM_KEYS-1:0] keys;
  sample_t             adc_data;
  logic                adc_valid;
  sample_t             udp_rx_data;
  logic                udp_rx_valid;
  sample_t             link_data;
  logic                link_valid;
  logic                tx_credit = 1'b0;
  sample_t             tx_data;
  logic                tx_valid;
  logic                tx_sop;
  logic                tx_eop;
  logic                overflow;

  logic [NUM_KEYS-1:0] tb_mode = '0;  // model of the toggles
  sample_t             exp_q[$];      // bytes the fifo should hold
  int                  credit_q[$];   // cycle numbers of pending credit returns
  bit                  hold_credits = 1'b0;
  int                  errors = 0;
  int                  cycle_cnt = 0;
  int                  last_tx_cycle = 0;
  int                  tx_cnt = 0;
  int                  pkt_cnt = 0;
  int                  tx_pos = 0;    // byte position inside the packet

  collect_top #(
    .CNT_MAX   (CNT_MAX),
    .FIFO_DEPTH(FIFO_DEPTH),
    .PKT_LEN   (PKT_LEN),
    .CREDITS   (CREDITS)
  ) collect_top_inst (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .keys        (keys),
    .adc_data    (adc_data),
    .adc_valid   (adc_valid),
    .udp_rx_data (udp_rx_data),
    .udp_rx_valid(udp_rx_valid),
    .link_data   (link_data),
    .link_valid  (link_valid),
    .tx_credit   (tx_credit),
    .tx_data     (tx_data),
    .tx_valid    (tx_valid),
    .tx_sop      (tx_sop),
    .tx_eop      (tx_eop),
    .overflow    (overflow)
  );

  always #2 sys_clk = ~sys_clk;  // 4 ns period

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  // adc first, then udp, then link; no mode set takes nothing
  function automatic logic [8:0] pick_source(input logic [NUM_KEYS-1:0] mode,
                                             input sample_t a, input logic av,
                                             input sample_t u, input logic uv,
                                             input sample_t l, input logic lv);
    if (mode[1]) begin
      return {av, a};
    end else if (mode[2]) begin
      return {uv, u};
    end else if (mode[3]) begin
      return {lv, l};
    end
    return 9'h000;
  endfunction

  task automatic press_key(input int idx);
    @(negedge sys_clk);
    keys[idx] = 1'b0;
    repeat (8) @(negedge sys_clk);
    keys[idx] = 1'b1;
    repeat (8) @(negedge sys_clk);
    tb_mode[idx] = ~tb_mode[idx];  // dut toggled long before release ends
  endtask

  // n accepted bytes, only the first keep of them expected out
  task automatic drive_bytes(input int n, input int keep, input bit dense);
    int         taken;
    logic [8:0] pick;
    taken = 0;
    while (taken < n) begin
      @(negedge sys_clk);
      adc_data     = 8'($urandom);
      udp_rx_data  = 8'($urandom);
      link_data    = 8'($urandom);
      adc_valid    = dense ? 1'b1 : 1'($urandom_range(1));
      udp_rx_valid = dense ? 1'b1 : 1'($urandom_range(1));
      link_valid   = dense ? 1'b1 : 1'($urandom_range(1));
      pick = pick_source(tb_mode, adc_data, adc_valid, udp_rx_data, udp_rx_valid,
                         link_data, link_valid);
      if (pick[8]) begin
        taken++;
        if (taken <= keep) exp_q.push_back(pick[7:0]);
      end
    end
    @(negedge sys_clk);
    adc_valid    = 1'b0;
    udp_rx_valid = 1'b0;
    link_valid   = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(negedge sys_clk);
    repeat (6) @(negedge sys_clk);  // catches stray tx_valid
  endtask

  // compare process, also hands credits back after a random delay
  always @(negedge sys_clk) begin : compare_tx
    sample_t exp_byte;
    int      due;
    tx_credit = 1'b0;
    if (sys_rst_n && tx_valid) begin
      if (exp_q.size() == 0) begin
        $display("** Error at %0t: tx_valid with no byte expected", $time);
        errors++;
      end else begin
        exp_byte = exp_q.pop_front();
        check_eq(32'(tx_data), 32'(exp_byte), "tx_data");
      end
      check_eq(32'(tx_sop), 32'(tx_pos == 0), "tx_sop");
      check_eq(32'(tx_eop), 32'(tx_pos == PKT_LEN - 1), "tx_eop");
      if (tx_eop) pkt_cnt++;
      tx_pos = (tx_pos + 1) % PKT_LEN;
      tx_cnt++;
      last_tx_cycle = cycle_cnt;
      due = cycle_cnt + int'($urandom_range(5));
      if (credit_q.size() != 0 && due <= credit_q[$]) due = credit_q[$] + 1;
      credit_q.push_back(due);
    end
    if (!hold_credits && credit_q.size() != 0 && credit_q[0] <= cycle_cnt) begin
      void'(credit_q.pop_front());
      tx_credit = 1'b1;
    end
  end

  always @(posedge sys_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles with %0d bytes still expected",
               cycle_cnt, exp_q.size());
      $display("Something failed");
      $finish;
    end
  end

  initial begin
    int         start;
    void'($urandom(SEED));
    keys = '1;
    adc_data = '0;
    adc_valid = 1'b0;
    udp_rx_data = '0;
    udp_rx_valid = 1'b0;
    link_data = '0;
    link_valid = 1'b0;
    sys_rst_n = 1'b0;
    repeat (3) @(negedge sys_clk);
    sys_rst_n = 1'b1;

    // 1: all sources busy for more than a fifo worth, nothing may be taken
    repeat (FIFO_DEPTH + 4) begin
      @(negedge sys_clk);
      adc_data = 8'($urandom);
      adc_valid = 1'b1;
      udp_rx_valid = 1'b1;
      link_valid = 1'b1;
    end
    @(negedge sys_clk);
    adc_valid = 1'b0;
    udp_rx_valid = 1'b0;
    link_valid = 1'b0;
    repeat (6) @(negedge sys_clk);
    check_eq(32'(tx_cnt), 0, "bytes sent with no source");
    check_eq(32'(overflow), 0, "overflow after idle");

    // 2: adc stream, five packets
    press_key(1);
    press_key(0);
    start = pkt_cnt;
    drive_bytes(5 * PKT_LEN, 5 * PKT_LEN, 1'b0);
    wait_drain();
    check_eq(32'(pkt_cnt - start), 5, "adc packets");

    // 3: priority, then udp alone, then link alone
    press_key(2);
    press_key(3);
    drive_bytes(2 * PKT_LEN, 2 * PKT_LEN, 1'b0);
    wait_drain();
    press_key(1);
    drive_bytes(2 * PKT_LEN, 2 * PKT_LEN, 1'b0);
    wait_drain();
    press_key(2);
    start = pkt_cnt;
    drive_bytes(2 * PKT_LEN, 2 * PKT_LEN, 1'b0);
    wait_drain();
    check_eq(32'(pkt_cnt - start), 2, "link packets");

    // 4: credits withheld, sender stalls mid-packet
    while (credit_q.size() != 0) @(negedge sys_clk);
    hold_credits = 1'b1;
    drive_bytes(3 * PKT_LEN, 3 * PKT_LEN, 1'b1);
    repeat (20) @(negedge sys_clk);
    check_eq(32'(credit_q.size()), 32'(CREDITS), "credits spent at stall");
    check_eq(32'(cycle_cnt - last_tx_cycle >= 10), 1, "tx stalled without credit");
    check_eq(32'(tx_pos), 32'(CREDITS % PKT_LEN), "stall position in packet");
    hold_credits = 1'b0;
    wait_drain();
    check_eq(32'(overflow), 0, "overflow before fill test");

    // 5: transmit off, overfill, then drain exactly one fifo worth
    press_key(0);
    start = tx_cnt;
    drive_bytes(FIFO_DEPTH + 3, FIFO_DEPTH, 1'b1);
    repeat (4) @(negedge sys_clk);
    check_eq(32'(overflow), 1, "overflow after overfill");
    check_eq(32'(tx_cnt - start), 0, "bytes sent while disabled");
    start = pkt_cnt;
    press_key(0);
    wait_drain();
    check_eq(32'(pkt_cnt - start), 32'(FIFO_DEPTH / PKT_LEN), "packets after refill");

    $display("errors: %0d, bytes sent: %0d, packets: %0d", errors, tx_cnt, pkt_cnt);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
